// File: source/led_panel_pkg.sv
package led_panel_pkg;

  localparam int COLUMNS = 64;
  localparam int ROW_BITS = 5;   // Scan row inside one half of the panel
  localparam int PLANE_BITS = 2;

  typedef struct packed {
    logic red;
    logic green;
    logic blue;
  } rgb_t;

  // Request to bring one row pair into the row buffer
  typedef struct packed {
    logic [ROW_BITS-1:0]   row;
    logic [PLANE_BITS-1:0] plane;
  } load_req_t;

  // What the panel sees on each column clock
  typedef struct packed {
    rgb_t                rgb0;  // Upper half, rows 0 to 31
    rgb_t                rgb1;  // Lower half, rows 32 to 63
    logic [ROW_BITS-1:0] row;
  } panel_out_t;

endpackage

// File: source/led_frame_pkg.sv
package led_frame_pkg;

  localparam int ADDR_BITS = 6;  // Pad bit on top of the scan row
  localparam int WORDS = 64;

  // RGB332 pixel as stored in the frame memory
  typedef struct packed {
    logic [2:0] red;
    logic [2:0] green;
    logic [1:0] blue;
  } pixel_t;

  // One panel row, pixel 0 sits in the low bits and is column 0
  typedef pixel_t [led_panel_pkg::COLUMNS-1:0] fused_word_t;

  typedef struct packed {
    logic [ADDR_BITS-1:0] addr;
    fused_word_t          data;
  } mem_write_t;

endpackage

// File: source/frame_memory.sv
`timescale 1ns/1ps

module frame_memory (
  input  logic                                clk,
  input  led_frame_pkg::mem_write_t           wr,
  input  logic                                wr_en,
  input  logic                                rd,
  input  logic [led_frame_pkg::ADDR_BITS-1:0] addr,
  output led_frame_pkg::fused_word_t          rd_data
);
  import led_frame_pkg::*;

  fused_word_t mem [WORDS];

  // One port, so a write takes the cycle and a read waits for the next one
  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr.addr] <= wr.data;
    end else if (rd) begin
      rd_data <= mem[addr];  // Holds until the next read
    end
  end

endmodule

// File: source/plane_selection.sv
`timescale 1ns/1ps

module plane_selection (
  input  logic [led_panel_pkg::PLANE_BITS-1:0] plane,
  input  led_frame_pkg::fused_word_t           row_data,
  output logic [led_panel_pkg::COLUMNS-1:0]    red,
  output logic [led_panel_pkg::COLUMNS-1:0]    green,
  output logic [led_panel_pkg::COLUMNS-1:0]    blue
);
  import led_panel_pkg::*;
  import led_frame_pkg::*;

  always_comb begin
    pixel_t pix;
    for (int c = 0; c < COLUMNS; c++) begin
      pix = row_data[c];
      case (plane)
        2'd0: begin
          red[c]   = pix.red[0];
          green[c] = pix.green[0];
          blue[c]  = pix.blue[0];
        end
        2'd1: begin
          red[c]   = pix.red[1];
          green[c] = pix.green[1];
          blue[c]  = pix.blue[1];
        end
        2'd2: begin
          red[c]   = pix.red[2];
          green[c] = pix.green[2];
          blue[c]  = 1'b0;  // Blue has only two bits
        end
        default: begin
          // Plane 3 blanks the panel
          red[c]   = 1'b0;
          green[c] = 1'b0;
          blue[c]  = 1'b0;
        end
      endcase
    end
  end

endmodule

// File: source/memory_management.sv
`timescale 1ns/1ps

module memory_management (
  input  logic                                 clk,
  input  logic                                 rst,
  input  led_panel_pkg::load_req_t             load_req,
  input  logic                                 load_valid,
  output logic                                 load_ready,
  input  logic                                 shift_valid,
  output logic                                 shift_ready,
  input  logic                                 wr_valid,
  output logic                                 wr_ready,
  output logic                                 wr_en,
  output logic                                 rd,
  output logic [led_frame_pkg::ADDR_BITS-1:0]  addr,
  output logic [led_panel_pkg::PLANE_BITS-1:0] plane,
  output logic                                 load0,
  output logic                                 load1,
  output logic                                 shift,
  output logic                                 plane_ready
);
  import led_panel_pkg::*;
  import led_frame_pkg::*;

  typedef enum logic [2:0] {
    START,
    SHIFT_P,
    S_CACHE0,
    S_LOAD0,
    S_CACHE1,
    S_LOAD1,
    DONE
  } state_t;

  state_t                        state;
  logic [ADDR_BITS-ROW_BITS-1:0] pad;  // Selects the upper or lower half of the panel
  logic [ROW_BITS-1:0]           row_q;
  logic                          load_accept;

  // Shift requests win over loads
  assign load_ready  = (state == START) && !shift_valid;
  assign shift_ready = (state == START) || (state == SHIFT_P);
  assign load_accept = load_valid && load_ready;

  // The RAM has one port, so writes wait while a row pair is being read
  assign wr_ready = !(state inside {S_CACHE0, S_LOAD0, S_CACHE1, S_LOAD1});
  assign wr_en    = wr_valid && wr_ready;

  assign addr = {pad, row_q};

  always_ff @(posedge clk) begin
    if (load_accept) begin
      row_q <= load_req.row;
      plane <= load_req.plane;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state       <= START;
      rd          <= 1'b0;
      load0       <= 1'b0;
      load1       <= 1'b0;
      shift       <= 1'b0;
      plane_ready <= 1'b0;
      pad         <= '0;
    end else begin
      // Every strobe lasts one cycle unless a state raises it again
      rd          <= 1'b0;
      load0       <= 1'b0;
      load1       <= 1'b0;
      shift       <= 1'b0;
      plane_ready <= 1'b0;
      case (state)
        START: begin
          if (shift_valid) begin
            shift <= 1'b1;
            state <= SHIFT_P;
          end else if (load_valid) begin
            rd    <= 1'b1;  // Upper half first
            pad   <= '0;
            state <= S_CACHE0;
          end
        end
        SHIFT_P: begin
          if (shift_valid) begin
            shift <= 1'b1;
          end else begin
            state <= START;
          end
        end
        S_CACHE0: begin
          load0 <= 1'b1;  // RAM output now holds row r
          state <= S_LOAD0;
        end
        S_LOAD0: begin
          rd    <= 1'b1;
          pad   <= '1;  // Row r+32
          state <= S_CACHE1;
        end
        S_CACHE1: begin
          load1 <= 1'b1;
          state <= S_LOAD1;
        end
        S_LOAD1: begin
          plane_ready <= 1'b1;  // Both banks are in place on this edge
          state       <= DONE;
        end
        DONE: begin
          state <= START;
        end
        default: begin
          state <= START;
        end
      endcase
    end
  end

endmodule

// File: source/row_buffer.sv
`timescale 1ns/1ps

module row_buffer (
  input  logic                               clk,
  input  logic                               rst,
  input  logic [led_panel_pkg::COLUMNS-1:0]  red,
  input  logic [led_panel_pkg::COLUMNS-1:0]  green,
  input  logic [led_panel_pkg::COLUMNS-1:0]  blue,
  input  logic                               load0,
  input  logic                               load1,
  input  logic                               shift,
  input  logic                               plane_ready,
  input  logic [led_panel_pkg::ROW_BITS-1:0] row,
  output led_panel_pkg::panel_out_t          panel
);
  import led_panel_pkg::*;

  // Bank 0 drives the upper half, bank 1 the lower half
  logic [COLUMNS-1:0]  red_q   [2];
  logic [COLUMNS-1:0]  green_q [2];
  logic [COLUMNS-1:0]  blue_q  [2];
  logic [ROW_BITS-1:0] row_q;
  logic [1:0]          load;

  assign load = {load1, load0};

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int b = 0; b < 2; b++) begin
        red_q[b]   <= '0;
        green_q[b] <= '0;
        blue_q[b]  <= '0;
      end
      row_q <= '0;
    end else begin
      for (int b = 0; b < 2; b++) begin
        if (load[b]) begin
          red_q[b]   <= red;
          green_q[b] <= green;
          blue_q[b]  <= blue;
        end else if (shift) begin
          red_q[b]   <= red_q[b] >> 1;  // Next column moves to bit 0
          green_q[b] <= green_q[b] >> 1;
          blue_q[b]  <= blue_q[b] >> 1;
        end
      end
      if (plane_ready) begin
        row_q <= row;
      end
    end
  end

  always_comb begin
    panel.rgb0.red   = red_q[0][0];
    panel.rgb0.green = green_q[0][0];
    panel.rgb0.blue  = blue_q[0][0];
    panel.rgb1.red   = red_q[1][0];
    panel.rgb1.green = green_q[1][0];
    panel.rgb1.blue  = blue_q[1][0];
    // The new row shows during the ready pulse and is held after it
    panel.row = plane_ready ? row : row_q;
  end

endmodule

// File: source/led_matrix_top.sv
`timescale 1ns/1ps

module led_matrix_top (
  input  logic                      clk,
  input  logic                      rst,
  input  led_frame_pkg::mem_write_t wr,
  input  logic                      wr_valid,
  output logic                      wr_ready,
  input  led_panel_pkg::load_req_t  load_req,
  input  logic                      load_valid,
  output logic                      load_ready,
  input  logic                      shift_valid,
  output logic                      shift_ready,
  output logic                      plane_ready,
  output led_panel_pkg::panel_out_t panel
);
  import led_panel_pkg::*;
  import led_frame_pkg::*;

  logic                  wr_en;
  logic                  rd;
  logic                  load0;
  logic                  load1;
  logic                  shift;
  logic [ADDR_BITS-1:0]  addr;
  logic [PLANE_BITS-1:0] plane;
  fused_word_t           rd_data;
  logic [COLUMNS-1:0]    red;
  logic [COLUMNS-1:0]    green;
  logic [COLUMNS-1:0]    blue;

  frame_memory u_frame_memory (
    .clk     (clk),
    .wr      (wr),
    .wr_en   (wr_en),
    .rd      (rd),
    .addr    (addr),
    .rd_data (rd_data)
  );

  memory_management u_memory_management (
    .clk         (clk),
    .rst         (rst),
    .load_req    (load_req),
    .load_valid  (load_valid),
    .load_ready  (load_ready),
    .shift_valid (shift_valid),
    .shift_ready (shift_ready),
    .wr_valid    (wr_valid),
    .wr_ready    (wr_ready),
    .wr_en       (wr_en),
    .rd          (rd),
    .addr        (addr),
    .plane       (plane),
    .load0       (load0),
    .load1       (load1),
    .shift       (shift),
    .plane_ready (plane_ready)
  );

  plane_selection u_plane_selection (
    .plane    (plane),
    .row_data (rd_data),
    .red      (red),
    .green    (green),
    .blue     (blue)
  );

  // Low address bits carry the latched scan row
  row_buffer u_row_buffer (
    .clk         (clk),
    .rst         (rst),
    .red         (red),
    .green       (green),
    .blue        (blue),
    .load0       (load0),
    .load1       (load1),
    .shift       (shift),
    .plane_ready (plane_ready),
    .row         (addr[ROW_BITS-1:0]),
    .panel       (panel)
  );

endmodule

// File: sim/clock_gen.sv
`timescale 1ns/1ps

module clock_gen (
  output logic clk,
  output logic rst
);
  localparam int HALF_PERIOD_NS = 10;
  localparam int RESET_CYCLES = 4;

  initial begin
    clk = 1'b0;
    forever #HALF_PERIOD_NS clk = ~clk;
  end

  initial begin
    rst = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;  // Released between edges
  end

endmodule

// File: sim/led_matrix_properties.sv
`timescale 1ns/1ps

module led_matrix_properties (
  input logic                                clk,
  input logic                                rst,
  input logic                                rd,
  input logic [led_frame_pkg::ADDR_BITS-1:0] addr,
  input logic                                load0,
  input logic                                load1,
  input logic                                plane_ready,
  input logic                                wr_en
);
  import led_frame_pkg::*;

  int failures = 0;  // Added to the closing count of the testbench

  // The upper half read is captured one cycle later
  upper_read_a: assert property (@(posedge clk) disable iff (rst)
    rd && !addr[ADDR_BITS-1] |=> load0)
  else begin
    failures++;
    $error("upper half read was not followed by load0");
  end

  // Capturing bank 0 is followed by a single read of the lower half
  lower_read_a: assert property (@(posedge clk) disable iff (rst)
    load0 |-> !rd ##1 (rd && addr[ADDR_BITS-1]) ##1 !rd)
  else begin
    failures++;
    $error("load0 was not followed by one read of the lower half");
  end

  one_bank_a: assert property (@(posedge clk) disable iff (rst) !(load0 && load1))
  else begin
    failures++;
    $error("both banks were loaded in the same cycle");
  end

  ready_pulse_a: assert property (@(posedge clk) disable iff (rst)
    plane_ready |=> !plane_ready)
  else begin
    failures++;
    $error("plane_ready stayed high for more than one cycle");
  end

  // The RAM has a single port
  port_conflict_a: assert property (@(posedge clk) disable iff (rst) !(wr_en && rd))
  else begin
    failures++;
    $error("a write and a read hit the frame memory together");
  end

endmodule

bind memory_management led_matrix_properties props0 (
  .clk         (clk),
  .rst         (rst),
  .rd          (rd),
  .addr        (addr),
  .load0       (load0),
  .load1       (load1),
  .plane_ready (plane_ready),
  .wr_en       (wr_en)
);

// File: sim/tb_led_matrix.sv
`timescale 1ns/1ps

module tb_led_matrix;
  import led_panel_pkg::*;
  import led_frame_pkg::*;

  localparam int WAIT_LIMIT = 16;
  localparam int TEST_CYCLES = 10 + 30 + 75 + 90 + 40 + 50;  // One term per test, in order
  localparam int WATCHDOG_NS = 2 * TEST_CYCLES * 20;

  logic                clk;
  logic                rst;
  mem_write_t          wr;
  logic                wr_valid;
  logic                wr_ready;
  load_req_t           load_req;
  logic                load_valid;
  logic                load_ready;
  logic                shift_valid;
  logic                shift_ready;
  logic                plane_ready;
  panel_out_t          panel;
  fused_word_t         model_mem [WORDS];  // What the frame memory should hold
  logic [ROW_BITS-1:0] test_row;
  int                  seed = 32'h0c38_41ac;
  int                  value_errors = 0;
  int                  wait_errors = 0;
  int                  total_errors;

  clock_gen clock0 (.clk(clk), .rst(rst));

  led_matrix_top dut0 (.*);

  function automatic fused_word_t random_word();
    logic [COLUMNS*$bits(pixel_t)-1:0] bits;
    for (int i = 0; i < COLUMNS * $bits(pixel_t) / 32; i++) begin
      bits[i*32 +: 32] = $random(seed);
    end
    return bits;
  endfunction

  // Red and green have planes 0 to 2, blue only 0 and 1, plane 3 is dark
  function automatic rgb_t plane_bits(pixel_t pix, logic [PLANE_BITS-1:0] plane);
    rgb_t bits;
    bits = '0;
    if (plane != 2'd3) begin
      bits.red   = pix.red[plane];
      bits.green = pix.green[plane];
      if (plane != 2'd2) begin
        bits.blue = pix.blue[plane[0]];
      end
    end
    return bits;
  endfunction

  function automatic rgb_t expected_rgb(logic [ADDR_BITS-1:0] addr, int col,
                                        logic [PLANE_BITS-1:0] plane);
    if (col >= COLUMNS) begin
      return '0;  // Everything has been shifted out
    end
    return plane_bits(model_mem[addr][col], plane);
  endfunction

  task automatic check_rgb(input string name, input rgb_t actual, input rgb_t expected);
    if (actual !== expected) begin
      value_errors++;
      $display("error: %s = 0x%h, expected 0x%h at %0t", name, actual, expected, $time);
    end
  endtask

  task automatic check_row(input string name, input logic [ROW_BITS-1:0] actual,
                           input logic [ROW_BITS-1:0] expected);
    if (actual !== expected) begin
      value_errors++;
      $display("error: %s = 0x%h, expected 0x%h at %0t", name, actual, expected, $time);
    end
  endtask

  task automatic check_bit(input string name, input logic actual, input logic expected);
    if (actual !== expected) begin
      value_errors++;
      $display("error: %s = 0x%h, expected 0x%h at %0t", name, actual, expected, $time);
    end
  endtask

  task automatic handshake_timeout(input string what);
    wait_errors++;
    $display("Timeout at %0t: %s", $time, what);
  endtask

  task automatic check_columns(input logic [ROW_BITS-1:0] row, input int col,
                               input logic [PLANE_BITS-1:0] plane);
    check_rgb("panel.rgb0", panel.rgb0, expected_rgb({1'b0, row}, col, plane));
    check_rgb("panel.rgb1", panel.rgb1, expected_rgb({1'b1, row}, col, plane));
  endtask

  task automatic write_word(input logic [ADDR_BITS-1:0] addr, input fused_word_t data);
    int waited;
    waited = 0;
    @(negedge clk);
    wr.addr  = addr;
    wr.data  = data;
    wr_valid = 1'b1;
    while (!wr_ready && waited < WAIT_LIMIT) begin
      @(negedge clk);
      waited++;
    end
    if (!wr_ready) begin
      handshake_timeout("frame memory write was never accepted");
    end else begin
      model_mem[addr] = data;
    end
    @(negedge clk);  // The write took the edge in between
    wr_valid = 1'b0;
  endtask

  // Ends at the falling edge after the pulse, with the controller back in START
  task automatic wait_plane_ready(input logic [ROW_BITS-1:0] row);
    int waited;
    waited = 0;
    while (!plane_ready && waited < WAIT_LIMIT) begin
      @(negedge clk);
      waited++;
    end
    if (!plane_ready) begin
      handshake_timeout("plane_ready never pulsed after a load");
    end else begin
      check_row("panel.row", panel.row, row);
    end
    @(negedge clk);
    check_bit("plane_ready", plane_ready, 1'b0);
  endtask

  task automatic load_row(input logic [ROW_BITS-1:0] row, input logic [PLANE_BITS-1:0] plane);
    int waited;
    waited = 0;
    @(negedge clk);
    load_req.row   = row;
    load_req.plane = plane;
    load_valid     = 1'b1;
    while (!load_ready && waited < WAIT_LIMIT) begin
      @(negedge clk);
      waited++;
    end
    if (!load_ready) begin
      handshake_timeout("load request was never accepted");
    end
    @(negedge clk);
    load_valid = 1'b0;
    wait_plane_ready(row);
  endtask

  // A column is shifted one cycle after each accepted request
  task automatic shift_columns(input int count, input int first, input logic [ROW_BITS-1:0] row,
                               input logic [PLANE_BITS-1:0] plane);
    @(negedge clk);
    check_bit("shift_ready", shift_ready, 1'b1);
    shift_valid = 1'b1;
    for (int k = 1; k <= count; k++) begin
      @(negedge clk);
      if (k == count) begin
        shift_valid = 1'b0;
      end
      check_columns(row, first + k - 1, plane);
    end
    @(negedge clk);
    check_columns(row, first + count, plane);
  endtask

  task automatic reset_test();
    @(negedge rst);
    @(negedge clk);
    check_bit("load_ready", load_ready, 1'b1);
    check_bit("shift_ready", shift_ready, 1'b1);
    check_bit("wr_ready", wr_ready, 1'b1);
    check_bit("plane_ready", plane_ready, 1'b0);
    check_rgb("panel.rgb0", panel.rgb0, '0);
    check_rgb("panel.rgb1", panel.rgb1, '0);
    check_row("panel.row", panel.row, '0);
  endtask

  task automatic plane0_load_test();
    int rnd;
    rnd = $random(seed);
    test_row = rnd[ROW_BITS-1:0];
    write_word({1'b0, test_row}, random_word());
    write_word({1'b1, test_row}, random_word());
    load_row(test_row, 2'd0);
    check_row("panel.row", panel.row, test_row);
    check_columns(test_row, 0, 2'd0);
  endtask

  task automatic full_shift_test();
    shift_columns(COLUMNS - 1, 0, test_row, 2'd0);
    shift_columns(1, COLUMNS - 1, test_row, 2'd0);  // Column 64 reads as zero
    check_row("panel.row", panel.row, test_row);
  endtask

  task automatic plane_test();
    logic [PLANE_BITS-1:0] plane;
    for (int p = 1; p < 4; p++) begin
      plane = p[PLANE_BITS-1:0];
      load_row(test_row, plane);
      check_columns(test_row, 0, plane);
      shift_columns(8, 0, test_row, plane);
    end
  endtask

  task automatic held_write_test();
    fused_word_t         fresh;
    logic [ROW_BITS-1:0] row;
    int                  rnd;
    rnd = $random(seed);
    row = rnd[ROW_BITS-1:0];
    write_word({1'b0, row}, random_word());
    write_word({1'b1, row}, random_word());
    fresh = random_word();
    @(negedge clk);
    load_req.row   = row;
    load_req.plane = 2'd0;
    load_valid     = 1'b1;
    check_bit("load_ready", load_ready, 1'b1);
    @(negedge clk);
    load_valid = 1'b0;
    wr.addr    = {1'b0, row};
    wr.data    = fresh;
    wr_valid   = 1'b1;
    for (int k = 0; k < 4; k++) begin
      check_bit("wr_ready", wr_ready, 1'b0);  // Four read states
      @(negedge clk);
    end
    check_bit("wr_ready", wr_ready, 1'b1);
    check_bit("plane_ready", plane_ready, 1'b1);
    check_columns(row, 0, 2'd0);  // Still the data from before the write
    @(negedge clk);
    wr_valid = 1'b0;
    model_mem[{1'b0, row}] = fresh;
    load_row(row, 2'd0);
    check_columns(row, 0, 2'd0);
    shift_columns(4, 0, row, 2'd0);
  endtask

  task automatic priority_test();
    logic [ROW_BITS-1:0] row_a;
    logic [ROW_BITS-1:0] row_b;
    int                  rnd;
    rnd   = $random(seed);
    row_a = rnd[ROW_BITS-1:0];
    row_b = row_a + 5'd7;
    write_word({1'b0, row_a}, random_word());
    write_word({1'b1, row_a}, random_word());
    write_word({1'b0, row_b}, random_word());
    write_word({1'b1, row_b}, random_word());
    load_row(row_a, 2'd1);
    @(negedge clk);
    shift_valid    = 1'b1;
    load_valid     = 1'b1;
    load_req.row   = row_b;
    load_req.plane = 2'd0;
    for (int k = 0; k < 5; k++) begin
      @(negedge clk);
      check_bit("load_ready", load_ready, 1'b0);
      check_bit("shift_ready", shift_ready, 1'b1);
      check_row("panel.row", panel.row, row_a);
    end
    shift_valid = 1'b0;
    check_bit("load_ready", load_ready, 1'b0);  // Idle cycle in SHIFT_P
    @(negedge clk);
    check_bit("load_ready", load_ready, 1'b1);
    check_columns(row_a, 5, 2'd1);
    @(negedge clk);
    load_valid = 1'b0;
    wait_plane_ready(row_b);
    check_columns(row_b, 0, 2'd0);
  endtask

  initial begin
    #(WATCHDOG_NS);
    $display("Watchdog expired after %0d ns with tests still running", WATCHDOG_NS);
    $display("Something failed");
    $finish;
  end

  initial begin
    wr          = '0;
    wr_valid    = 1'b0;
    load_req    = '0;
    load_valid  = 1'b0;
    shift_valid = 1'b0;
    reset_test();
    plane0_load_test();
    full_shift_test();
    plane_test();
    held_write_test();
    priority_test();
    total_errors = value_errors + wait_errors + dut0.u_memory_management.props0.failures;
    $display("Result: %0d value errors, %0d handshake timeouts, %0d assertion failures",
             value_errors, wait_errors, dut0.u_memory_management.props0.failures);
    if (total_errors == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

// File: led_matrix.f
source/led_panel_pkg.sv
source/led_frame_pkg.sv
source/frame_memory.sv
source/plane_selection.sv
source/memory_management.sv
source/row_buffer.sv
source/led_matrix_top.sv
sim/clock_gen.sv
sim/led_matrix_properties.sv
sim/tb_led_matrix.sv

// File: run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module tb_led_matrix -f led_matrix.f \
  -o sim_led_matrix || { echo "Verilator build failed"; exit 1; }
output=$(./obj_dir/sim_led_matrix +verilator+error+limit+1000)
echo "$output"
echo "$output" | grep -qx "Everything OK" && echo "Simulation passed" && exit 0 \
  || { echo "Simulation did not pass"; exit 1; }
